// ==== include/rv_exec_config.svh ====
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// ********************
// datapath widths
// ********************

// width of a data word, a pc and an immediate.
`define RV_XLEN 32

// register index width, enough for x0 to x31.
`define RV_REG_BITS 5

// ********************
// control flow
// ********************

// the link address of a jump is pc plus this step.
`define RV_PC_STEP 4

`endif

// ==== hdl/rv_exec_pkg.sv ====
`include "rv_exec_config.svh"

package rv_exec_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_BITS-1:0] reg_idx_t;

  // ********************
  // control encodings
  // ********************

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B // b goes straight to the result, used by lui.
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_RS1_RS2,
    SRC_RS1_IMM,
    SRC_PC_STEP,
    SRC_PC_IMM
  } src_sel_e;

  typedef enum logic [1:0] {
    REDIR_NONE,
    REDIR_BRANCH,
    REDIR_JAL,
    REDIR_JALR
  } redir_e;

  // ********************
  // stage payloads
  // ********************

  typedef struct packed {
    alu_op_e    alu_op;
    src_sel_e   src_sel;
    redir_e     redir;
    logic [2:0] funct3; // picks the branch condition.
    reg_idx_t   rd;
    logic       wen;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    word_t pc;
    word_t src1;
    word_t src2;
    word_t imm;
    ctrl_t ctrl;
  } issue_t;

  typedef struct packed {
    word_t    result;
    reg_idx_t rd;
    logic     wen;
    logic     taken;
    word_t    target;
    logic     illegal;
  } result_t;

endpackage

// ==== hdl/rv_alu.sv ====
`include "rv_exec_config.svh"

module rv_alu (
  input  rv_exec_pkg::alu_op_e op,
  input  rv_exec_pkg::word_t   a,
  input  rv_exec_pkg::word_t   b,
  output rv_exec_pkg::word_t   y,
  output logic                 carry
);
  import rv_exec_pkg::*;

  localparam int SHAMT_BITS = $clog2(`RV_XLEN);

  logic [SHAMT_BITS-1:0] shamt;
  logic [`RV_XLEN:0]     diff_ext;
  word_t                 diff;
  logic                  lt_signed;
  logic                  lt_unsigned;

  assign shamt = b[SHAMT_BITS-1:0];

  // the extra top bit of the subtraction is the borrow.
  assign diff_ext = {1'b0, a} - {1'b0, b};
  assign diff     = diff_ext[`RV_XLEN-1:0];
  assign carry    = diff_ext[`RV_XLEN];

  assign lt_unsigned = carry;
  assign lt_signed   = (a[`RV_XLEN-1] != b[`RV_XLEN-1]) ? a[`RV_XLEN-1]
                                                        : diff[`RV_XLEN-1];

  // ********************
  // operation select
  // ********************

  always_comb begin
    unique case (op)
      ALU_ADD:    y = a + b;
      ALU_SUB:    y = diff;
      ALU_SLL:    y = a << shamt;
      ALU_SLT:    y = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   y = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    y = a ^ b;
      ALU_SRL:    y = a >> shamt;
      ALU_SRA:    y = word_t'($signed(a) >>> shamt); // sign fills from the left.
      ALU_OR:     y = a | b;
      ALU_AND:    y = a & b;
      ALU_PASS_B: y = b;
      default:    y = '0;
    endcase
  end

endmodule

// ==== hdl/rv_decode.sv ====
`include "rv_exec_config.svh"

module rv_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  rv_exec_pkg::word_t   instr,
  input  rv_exec_pkg::word_t   pc,
  input  rv_exec_pkg::word_t   src1,
  input  rv_exec_pkg::word_t   src2,
  output logic                 dec_valid,
  output rv_exec_pkg::issue_t  dec
);
  import rv_exec_pkg::*;

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5; // separates sub from add and sra from srl.
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_b;
  word_t      imm_j;
  ctrl_t      ctrl_d;
  word_t      imm_d;
  alu_op_e    arith_op;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7_b5 = instr[30];

  assign imm_i = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
  assign imm_u = word_t'({instr[31:12], 12'h000});
  assign imm_b = {{(`RV_XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{(`RV_XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // shared funct3 table of op and op-imm.
  always_comb begin
    unique case (funct3)
      3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    ctrl_d         = '0;
    ctrl_d.alu_op  = ALU_ADD;
    ctrl_d.src_sel = SRC_RS1_RS2;
    ctrl_d.redir   = REDIR_NONE;
    ctrl_d.funct3  = funct3;
    ctrl_d.rd      = instr[11:7];
    ctrl_d.wen     = 1'b1;
    imm_d          = imm_i;
    unique case (opcode)
      OPC_OP:     ctrl_d.alu_op = arith_op;
      OPC_OP_IMM: begin
        ctrl_d.alu_op  = arith_op;
        ctrl_d.src_sel = SRC_RS1_IMM;
      end
      OPC_LUI: begin
        ctrl_d.alu_op  = ALU_PASS_B;
        ctrl_d.src_sel = SRC_RS1_IMM;
        imm_d          = imm_u;
      end
      OPC_AUIPC: begin
        ctrl_d.src_sel = SRC_PC_IMM;
        imm_d          = imm_u;
      end
      OPC_JAL: begin
        ctrl_d.redir = REDIR_JAL;
        imm_d        = imm_j;
      end
      OPC_JALR:   ctrl_d.redir = REDIR_JALR; // target uses the i immediate.
      OPC_BRANCH: begin
        ctrl_d.redir = REDIR_BRANCH;
        imm_d        = imm_b;
      end
      default: begin
        ctrl_d.illegal = 1'b1;
        ctrl_d.wen     = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      dec.pc   <= pc;
      dec.src1 <= src1;
      dec.src2 <= src2;
      dec.imm  <= imm_d;
      dec.ctrl <= ctrl_d;
    end
  end

endmodule

// ==== hdl/rv_exu.sv ====
`include "rv_exec_config.svh"

module rv_exu (
  input  rv_exec_pkg::issue_t dec,
  output rv_exec_pkg::word_t  alu_result,
  output logic                taken
);
  import rv_exec_pkg::*;

  alu_op_e  op;
  src_sel_e sel;
  word_t    alu_a;
  word_t    alu_b;
  logic     borrow;
  logic     zero;
  logic     lt_signed;

  // redirect kinds override the decoded operand pair and operation.
  always_comb begin
    op  = dec.ctrl.alu_op;
    sel = dec.ctrl.src_sel;
    unique case (dec.ctrl.redir)
      REDIR_BRANCH: begin
        op  = ALU_SUB;
        sel = SRC_RS1_RS2;
      end
      REDIR_JAL, REDIR_JALR: begin
        op  = ALU_ADD;
        sel = SRC_PC_STEP; // the result is the link address.
      end
      default: ;
    endcase
  end

  always_comb begin
    unique case (sel)
      SRC_RS1_RS2: {alu_a, alu_b} = {dec.src1, dec.src2};
      SRC_RS1_IMM: {alu_a, alu_b} = {dec.src1, dec.imm};
      SRC_PC_STEP: {alu_a, alu_b} = {dec.pc, word_t'(`RV_PC_STEP)};
      default:     {alu_a, alu_b} = {dec.pc, dec.imm};
    endcase
  end

  rv_alu rv_alu_i (
    .op    (op),
    .a     (alu_a),
    .b     (alu_b),
    .y     (alu_result),
    .carry (borrow)
  );

  // ********************
  // branch resolution
  // ********************

  assign zero = ~(|alu_result);

  // the sign of the difference is wrong on overflow, so differing signs decide directly.
  assign lt_signed = (alu_a[`RV_XLEN-1] != alu_b[`RV_XLEN-1]) ? alu_a[`RV_XLEN-1]
                                                              : alu_result[`RV_XLEN-1];

  always_comb begin
    taken = 1'b0;
    unique case (dec.ctrl.redir)
      REDIR_BRANCH: begin
        unique case (dec.ctrl.funct3)
          3'b000:  taken = zero;       // beq.
          3'b001:  taken = ~zero;      // bne.
          3'b100:  taken = lt_signed;  // blt.
          3'b101:  taken = ~lt_signed; // bge.
          3'b110:  taken = borrow;     // bltu.
          3'b111:  taken = ~borrow;    // bgeu.
          default: taken = 1'b0;
        endcase
      end
      REDIR_JAL, REDIR_JALR: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

endmodule

// ==== hdl/rv_commit.sv ====
module rv_commit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 dec_valid,
  input  rv_exec_pkg::issue_t  dec,
  input  rv_exec_pkg::word_t   alu_result,
  input  logic                 taken,
  output logic                 out_valid,
  output rv_exec_pkg::result_t res
);
  import rv_exec_pkg::*;

  word_t   pc_target;
  word_t   reg_target;
  word_t   target;
  result_t res_d;

  assign pc_target  = dec.pc + dec.imm;
  assign reg_target = (dec.src1 + dec.imm) & ~word_t'(1); // jalr drops bit 0.

  always_comb begin
    if (!taken) begin
      target = '0;
    end else if (dec.ctrl.redir == REDIR_JALR) begin
      target = reg_target;
    end else begin
      target = pc_target;
    end
  end

  always_comb begin
    res_d.result  = dec.ctrl.illegal ? '0 : alu_result;
    res_d.rd      = dec.ctrl.rd;
    res_d.wen     = dec.ctrl.wen && (dec.ctrl.redir != REDIR_BRANCH); // branches write nothing.
    res_d.taken   = taken;
    res_d.target  = target;
    res_d.illegal = dec.ctrl.illegal;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      res <= res_d;
    end
  end

endmodule

// ==== hdl/rv_exec_top.sv ====
module rv_exec_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_valid,
  input  rv_exec_pkg::word_t   instr,
  input  rv_exec_pkg::word_t   pc,
  input  rv_exec_pkg::word_t   src1,
  input  rv_exec_pkg::word_t   src2,
  output logic                 out_valid,
  output rv_exec_pkg::result_t res
);
  import rv_exec_pkg::*;

  logic   dec_valid;
  issue_t dec;
  word_t  alu_result;
  logic   taken;

  rv_decode rv_decode_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .src1      (src1),
    .src2      (src2),
    .dec_valid (dec_valid),
    .dec       (dec)
  );

  rv_exu rv_exu_i (
    .dec        (dec),
    .alu_result (alu_result),
    .taken      (taken)
  );

  rv_commit rv_commit_i (
    .clk        (clk),
    .rst        (rst),
    .dec_valid  (dec_valid),
    .dec        (dec),
    .alu_result (alu_result),
    .taken      (taken),
    .out_valid  (out_valid),
    .res        (res)
  );

endmodule

// ==== tests/rv_exec_properties.sv ====
`include "rv_exec_config.svh"

module rv_exec_properties (
  input logic                 clk,
  input logic                 rst,
  input logic                 in_valid,
  input rv_exec_pkg::word_t   instr,
  input rv_exec_pkg::word_t   pc,
  input rv_exec_pkg::word_t   src1,
  input rv_exec_pkg::word_t   src2,
  input logic                 out_valid,
  input rv_exec_pkg::result_t res
);
  import rv_exec_pkg::*;

  typedef struct packed {
    word_t instr;
    word_t pc;
    word_t src1;
    word_t src2;
  } sample_t;

  logic [1:0] hist_valid;
  sample_t    hist_1; // inputs of the previous edge.
  sample_t    hist_2; // inputs of two edges back, which leave the pipe now.
  result_t    exp;
  int         error_count = 0;

  // ********************
  // reference model
  // ********************

  function automatic result_t expected_result(sample_t s);
    result_t    r;
    logic [6:0] opc;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_j;
    logic [4:0] sh;
    r     = '0;
    opc   = s.instr[6:0];
    f3    = s.instr[14:12];
    a     = s.src1;
    imm_i = word_t'($signed(s.instr[31:20]));
    imm_b = word_t'($signed({s.instr[31], s.instr[7], s.instr[30:25], s.instr[11:8], 1'b0}));
    imm_j = word_t'($signed({s.instr[31], s.instr[19:12], s.instr[20], s.instr[30:21], 1'b0}));
    b     = (opc == 7'h33) ? s.src2 : imm_i; // register form against immediate form.
    sh    = b[4:0];
    r.rd  = s.instr[11:7];
    r.wen = 1'b1;
    case (opc)
      7'h33, 7'h13: begin
        case (f3)
          3'd0:    r.result = (opc == 7'h33 && s.instr[30]) ? a - b : a + b;
          3'd1:    r.result = a << sh;
          3'd2:    r.result = word_t'($signed(a) < $signed(b));
          3'd3:    r.result = word_t'(a < b);
          3'd4:    r.result = a ^ b;
          3'd5:    r.result = s.instr[30] ? word_t'($signed(a) >>> sh) : a >> sh;
          3'd6:    r.result = a | b;
          default: r.result = a & b;
        endcase
      end
      7'h37: r.result = {s.instr[31:12], 12'h000};
      7'h17: r.result = s.pc + {s.instr[31:12], 12'h000};
      7'h6f, 7'h67: begin
        r.result = s.pc + `RV_PC_STEP;
        r.taken  = 1'b1;
        r.target = (opc == 7'h6f) ? s.pc + imm_j : (a + imm_i) & ~word_t'(1);
      end
      7'h63: begin
        r.wen = 1'b0;
        case (f3)
          3'd0:    r.taken = (a == s.src2);
          3'd1:    r.taken = (a != s.src2);
          3'd4:    r.taken = ($signed(a) < $signed(s.src2));
          3'd5:    r.taken = ($signed(a) >= $signed(s.src2));
          3'd6:    r.taken = (a < s.src2);
          3'd7:    r.taken = (a >= s.src2);
          default: r.taken = 1'b0;
        endcase
        r.target = r.taken ? s.pc + imm_b : '0;
      end
      default: begin
        r.illegal = 1'b1;
        r.wen     = 1'b0;
      end
    endcase
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      hist_valid <= '0;
    end else begin
      hist_valid <= {hist_valid[0], in_valid};
    end
    hist_1 <= {instr, pc, src1, src2};
    hist_2 <= hist_1;
  end

  always_comb exp = expected_result(hist_2);

  // ********************
  // output checks
  // ********************

  a_valid: assert property (@(posedge clk) disable iff (rst) out_valid == hist_valid[1])
    else begin
      $error("FAILED t=%0t out_valid got %0b expected %0b", $time, $sampled(out_valid),
             $sampled(hist_valid[1]));
      error_count++;
    end

  a_result: assert property (@(posedge clk) disable iff (rst)
                             out_valid && (exp.wen || exp.illegal) |->
                             res.result == exp.result)
    else begin
      $error("FAILED t=%0t res.result got %h expected %h", $time, $sampled(res.result),
             $sampled(exp.result));
      error_count++;
    end

  a_rd: assert property (@(posedge clk) disable iff (rst) out_valid |-> res.rd == exp.rd)
    else begin
      $error("FAILED t=%0t res.rd got %0d expected %0d", $time, $sampled(res.rd),
             $sampled(exp.rd));
      error_count++;
    end

  a_wen: assert property (@(posedge clk) disable iff (rst) out_valid |-> res.wen == exp.wen)
    else begin
      $error("FAILED t=%0t res.wen got %0b expected %0b", $time, $sampled(res.wen),
             $sampled(exp.wen));
      error_count++;
    end

  a_taken: assert property (@(posedge clk) disable iff (rst)
                            out_valid |-> res.taken == exp.taken)
    else begin
      $error("FAILED t=%0t res.taken got %0b expected %0b", $time, $sampled(res.taken),
             $sampled(exp.taken));
      error_count++;
    end

  a_target: assert property (@(posedge clk) disable iff (rst)
                             out_valid |-> res.target == exp.target)
    else begin
      $error("FAILED t=%0t res.target got %h expected %h", $time, $sampled(res.target),
             $sampled(exp.target));
      error_count++;
    end

  a_illegal: assert property (@(posedge clk) disable iff (rst)
                              out_valid |-> res.illegal == exp.illegal)
    else begin
      $error("FAILED t=%0t res.illegal got %0b expected %0b", $time,
             $sampled(res.illegal), $sampled(exp.illegal));
      error_count++;
    end

endmodule

bind rv_exec_top rv_exec_properties rv_exec_properties_i (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .instr     (instr),
  .pc        (pc),
  .src1      (src1),
  .src2      (src2),
  .out_valid (out_valid),
  .res       (res)
);

// ==== tests/rv_exec_tb.sv ====
module rv_exec_tb;
  import rv_exec_pkg::*;

  localparam int         NUM_INSTR  = 2000;
  localparam longint     WATCHDOG   = 20 * NUM_INSTR * 3 * 8;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_AUIPC  = 7'h17;
  localparam logic [6:0] OPC_JAL    = 7'h6f;
  localparam logic [6:0] OPC_JALR   = 7'h67;
  localparam logic [6:0] OPC_BRANCH = 7'h63;

  // values around the signed and unsigned wrap points.
  localparam word_t EDGE_VALS [5] = '{32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff,
                                      32'h8000_0000, 32'hffff_ffff};
  localparam logic [2:0] BRANCH_F3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

  logic    clk;
  logic    rst;
  logic    in_valid;
  word_t   instr;
  word_t   pc;
  word_t   src1;
  word_t   src2;
  logic    out_valid;
  result_t res;
  word_t   lcg_state;
  int      issued;

  rv_exec_top rv_exec_top_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .instr     (instr),
    .pc        (pc),
    .src1      (src1),
    .src2      (src2),
    .out_valid (out_valid),
    .res       (res)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // ********************
  // stimulus helpers
  // ********************

  // two steps per call, keeping the stronger upper halves.
  function automatic word_t rand32();
    word_t hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi        = lcg_state;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi[31:16], lcg_state[31:16]};
  endfunction

  function automatic word_t pick_operand();
    word_t v;
    v = rand32();
    if (v[2:0] == 3'd0) begin
      return EDGE_VALS[v[5:3] % 5];
    end
    return rand32();
  endfunction

  function automatic logic is_supported(logic [6:0] opc);
    return opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd6, OPC_OP};
  endfunction

  function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd5, opc};
  endfunction

  function automatic word_t enc_branch(logic [2:0] f3, logic [12:0] imm);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  task automatic issue(input word_t ins, input word_t p, input word_t a, input word_t b);
    @(posedge clk);
    in_valid <= 1'b1;
    instr    <= ins;
    pc       <= p;
    src1     <= a;
    src2     <= b;
    issued++;
  endtask

  task automatic idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic run_directed();
    for (int k = 0; k < 6; k++) begin
      for (int x = 0; x < 5; x++) begin
        for (int y = 0; y < 5; y++) begin
          issue(enc_branch(BRANCH_F3[k], 13'h0020), 32'h0000_1000, EDGE_VALS[x], EDGE_VALS[y]);
        end
      end
    end
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        issue(enc_r(7'h00, 3'b010), 32'h0000_1100, EDGE_VALS[x], EDGE_VALS[y]);
        issue(enc_r(7'h00, 3'b011), 32'h0000_1104, EDGE_VALS[x], EDGE_VALS[y]);
      end
    end
    issue(enc_r(7'h20, 3'b101), 32'h0000_2000, 32'h8000_0000, 32'h0000_0024); // sra by 4.
    issue(enc_i(OPC_OP_IMM, 3'b101, 12'h41f), 32'h0000_2004, 32'hf000_0000, '0);
    issue(enc_i(OPC_JALR, 3'b000, 12'h005), 32'h0000_3000, 32'h0000_0100, '0);
    issue(enc_i(OPC_JALR, 3'b000, 12'hffd), 32'h0000_3004, 32'h0000_0200, '0);
    issue({20'habcde, 5'd3, OPC_LUI}, 32'h0000_3008, '0, '0);
    issue({20'h80000, 5'd4, OPC_AUIPC}, 32'h0000_4000, '0, '0);
    issue({1'b1, 10'h3fe, 1'b1, 8'hff, 5'd1, OPC_JAL}, 32'h0000_5000, '0, '0);
    issue(enc_i(7'h03, 3'b010, 12'h010), 32'h0000_5004, '0, '0); // load, unsupported here.
    idle();
  endtask

  task automatic issue_random();
    word_t      r;
    word_t      ins;
    word_t      a;
    word_t      b;
    logic [6:0] opc;
    r   = rand32();
    ins = rand32();
    a   = pick_operand();
    b   = (r[12:11] == 2'b00) ? a : pick_operand();
    case (r[2:0])
      3'd0:    opc = OPC_OP;
      3'd1:    opc = OPC_OP_IMM;
      3'd2:    opc = OPC_LUI;
      3'd3:    opc = OPC_AUIPC;
      3'd4:    opc = OPC_JAL;
      3'd5:    opc = OPC_JALR;
      3'd6:    opc = OPC_BRANCH;
      default: begin
        opc = ins[6:0];
        while (is_supported(opc)) opc = opc + 7'd1;
      end
    endcase
    ins[6:0] = opc;
    if (opc == OPC_BRANCH) begin
      ins[14:12] = BRANCH_F3[r[7:5] % 6];
    end
    issue(ins, rand32() & ~word_t'(3), a, b);
    if (r[9:8] == 2'b00) begin
      repeat (int'(r[14:13]) + 1) idle();
    end
  endtask

  // ********************
  // run control
  // ********************

  initial begin
    #(WATCHDOG);
    $display("watchdog expired with %0d of %0d instructions issued", issued, NUM_INSTR);
    $display("Test failed");
    $fatal(1, "simulation timeout");
  end

  always @(negedge clk) begin
    if (rv_exec_top_i.rv_exec_properties_i.error_count != 0) begin
      $display("Test failed");
      $fatal(1, "a result check reported a mismatch");
    end
  end

  initial begin
    lcg_state = 32'd90706;
    issued    = 0;
    rst       = 1'b1;
    in_valid  = 1'b0;
    instr     = '0;
    pc        = '0;
    src1      = '0;
    src2      = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (2) idle(); // out_valid has to stay low here.
    run_directed();
    while (issued < NUM_INSTR) issue_random();
    repeat (3) idle();
    @(negedge clk);
    if (rv_exec_top_i.rv_exec_properties_i.error_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "result checks reported mismatches");
    end
  end

endmodule

// ==== rv_exec_top.f ====
+incdir+include
hdl/rv_exec_pkg.sv
hdl/rv_alu.sv
hdl/rv_decode.sv
hdl/rv_exu.sv
hdl/rv_commit.sv
hdl/rv_exec_top.sv
tests/rv_exec_properties.sv
tests/rv_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_exec_tb
FILELIST  ?= rv_exec_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Test failed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the simulation and check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables:  VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Test completed successfully" $(LOG) || \
		{ echo "simulation ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
